// File: logic/corePkg.sv
`default_nettype none

package corePkg;

    localparam int XLen = 64;
    localparam logic [XLen-1:0] ResetPc = '0;

    //////////////////////////////
    // major opcodes.
    localparam logic [6:0] OpReg    = 7'b0110011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpBranch = 7'b1100011;

    localparam logic [2:0] F3AddSub = 3'b000;
    localparam logic [2:0] F3Xor    = 3'b100;
    localparam logic [2:0] F3Or     = 3'b110;
    localparam logic [2:0] F3And    = 3'b111;
    localparam logic [2:0] F3Beq    = 3'b000;
    localparam logic [2:0] F3Bne    = 3'b001;

    localparam logic [6:0] F7Base = 7'b0000000;
    localparam logic [6:0] F7Sub  = 7'b0100000; // sub only, alongside funct3 000.

    //////////////////////////////
    // one instruction word, two field layouts.
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm12;     // b-type keeps rs2 in the low five bits.
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;        // b-type offset bits 4:1 and 11.
            logic [6:0]  opcode;
        } ibType;
    } instrWord;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor
    } aluOp;

endpackage

`default_nettype wire

// File: logic/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [4:0]                  rs1Addr,
    input  logic [4:0]                  rs2Addr,
    output logic [corePkg::XLen-1:0]    rs1Data,
    output logic [corePkg::XLen-1:0]    rs2Data,
    input  logic                        writeEn,
    input  logic [4:0]                  writeAddr,
    input  logic [corePkg::XLen-1:0]    writeData
);

    logic [corePkg::XLen-1:0] regs [1:31]; // x0 has no storage.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != 5'd0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // x0 reads as zero.
    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

endmodule

`default_nettype wire

// File: logic/fetchUnit.sv
`timescale 1ns/1ns
`default_nettype none

module fetchUnit (
    input  logic                        clk,
    input  logic                        rst,
    output logic                        imemReqValid,
    output logic [corePkg::XLen-1:0]    imemAddr,
    input  logic                        imemReqReady,
    input  logic                        imemRespValid,
    input  logic [31:0]                 imemRespData,
    input  logic                        redirectValid,
    input  logic [corePkg::XLen-1:0]    redirectPc,
    output logic                        instValid,
    output logic [corePkg::XLen-1:0]    instPc,
    output corePkg::instrWord           instWord,
    input  logic                        instReady
);

    logic [corePkg::XLen-1:0] pc;         // next address to request.
    logic [corePkg::XLen-1:0] reqAddr;    // address of the request in flight.
    logic [corePkg::XLen-1:0] launchAddr;
    logic [corePkg::XLen-1:0] bufPc;
    corePkg::instrWord        bufWord;
    logic reqActive;
    logic pending;
    logic drop;
    logic bufValid;
    logic launch;
    logic respTake;

    // the buffer is free by the time the response can land.
    assign launch = !reqActive && !pending && (!bufValid || instReady || redirectValid);
    assign launchAddr = redirectValid ? redirectPc : pc;
    assign respTake = pending && imemRespValid && !drop && !redirectValid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= corePkg::ResetPc;
            reqActive <= 1'b0;
            pending <= 1'b0;
            drop <= 1'b0;
            bufValid <= 1'b0;
        end else begin
            if (redirectValid) pc <= redirectPc;
            if (launch) begin
                reqActive <= 1'b1;
                pc <= launchAddr + 4;
            end else if (reqActive && imemReqReady) begin
                reqActive <= 1'b0;
            end
            if (reqActive && imemReqReady) pending <= 1'b1;
            else if (pending && imemRespValid) pending <= 1'b0;
            // a response that shows up with the redirect is discarded right away.
            if (redirectValid && (reqActive || (pending && !imemRespValid))) drop <= 1'b1;
            else if (pending && imemRespValid) drop <= 1'b0;
            if (redirectValid) bufValid <= 1'b0;
            else if (respTake) bufValid <= 1'b1;
            else if (instReady) bufValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) reqAddr <= launchAddr;
        if (respTake) begin
            bufPc <= reqAddr;
            bufWord <= imemRespData;
        end
    end

    assign imemReqValid = reqActive;
    assign imemAddr = reqAddr;
    assign instValid = bufValid;
    assign instPc = bufPc;
    assign instWord = bufWord;

endmodule

`default_nettype wire

// File: logic/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        instValid,
    input  logic [corePkg::XLen-1:0]    instPc,
    input  corePkg::instrWord           instWord,
    output logic                        instReady,
    output logic [4:0]                  rs1Addr,
    output logic [4:0]                  rs2Addr,
    input  logic [corePkg::XLen-1:0]    rs1Data,
    input  logic [corePkg::XLen-1:0]    rs2Data,
    input  logic                        fwdValid,
    input  logic [4:0]                  fwdRd,
    input  logic [corePkg::XLen-1:0]    fwdData,
    output logic                        redirectValid,
    output logic [corePkg::XLen-1:0]    redirectPc,
    output logic                        exValid,
    output logic [corePkg::XLen-1:0]    exPc,
    output logic [4:0]                  exRd,
    output logic                        exWrite,
    output logic [corePkg::XLen-1:0]    exData,
    input  logic                        exReady
);

    logic [corePkg::XLen-1:0] op1, op2, operandB, aluResult;
    logic [corePkg::XLen-1:0] immI, immB, target, targetR;
    corePkg::aluOp op;
    logic writes;
    logic isBranch;
    logic taken;
    logic takenR;
    logic accept;

    assign rs1Addr = instWord.rType.rs1;
    assign rs2Addr = instWord.rType.rs2; // same bits as the b-type rs2.

    //////////////////////////////
    // operands.
    assign op1 = (fwdValid && rs1Addr != 5'd0 && fwdRd == rs1Addr) ? fwdData : rs1Data;
    assign op2 = (fwdValid && rs2Addr != 5'd0 && fwdRd == rs2Addr) ? fwdData : rs2Data;

    assign immI = {{(corePkg::XLen-12){instWord.ibType.imm12[11]}}, instWord.ibType.imm12};
    assign immB = {{(corePkg::XLen-13){instWord.ibType.imm12[11]}},
                   instWord.ibType.imm12[11], instWord.ibType.rd[0],
                   instWord.ibType.imm12[10:5], instWord.ibType.rd[4:1], 1'b0};

    //////////////////////////////
    // decode.
    always_comb begin
        op = corePkg::AluAdd;
        operandB = op2;
        writes = 1'b0;
        isBranch = 1'b0;
        case (instWord.rType.opcode)
            corePkg::OpReg: begin
                writes = (instWord.rType.funct7 == corePkg::F7Base);
                case (instWord.rType.funct3)
                    corePkg::F3AddSub: begin
                        if (instWord.rType.funct7 == corePkg::F7Sub) begin
                            op = corePkg::AluSub;
                            writes = 1'b1;
                        end
                    end
                    corePkg::F3Xor: op = corePkg::AluXor;
                    corePkg::F3Or:  op = corePkg::AluOr;
                    corePkg::F3And: op = corePkg::AluAnd;
                    default: writes = 1'b0; // shifts and compares are not supported.
                endcase
            end
            corePkg::OpImm: begin
                operandB = immI;
                writes = 1'b1;
                case (instWord.ibType.funct3)
                    corePkg::F3AddSub: op = corePkg::AluAdd;
                    corePkg::F3Xor:    op = corePkg::AluXor;
                    corePkg::F3Or:     op = corePkg::AluOr;
                    corePkg::F3And:    op = corePkg::AluAnd;
                    default: writes = 1'b0;
                endcase
            end
            corePkg::OpBranch: begin
                isBranch = (instWord.ibType.funct3 == corePkg::F3Beq) ||
                           (instWord.ibType.funct3 == corePkg::F3Bne);
            end
            default: ; // anything else retires as a no-op.
        endcase
        if (instWord.rType.rd == 5'd0) writes = 1'b0;
    end

    always_comb begin
        case (op)
            corePkg::AluSub: aluResult = op1 - operandB;
            corePkg::AluAnd: aluResult = op1 & operandB;
            corePkg::AluOr:  aluResult = op1 | operandB;
            corePkg::AluXor: aluResult = op1 ^ operandB;
            default:         aluResult = op1 + operandB;
        endcase
    end

    assign taken = isBranch && ((instWord.ibType.funct3 == corePkg::F3Beq) ?
                                (op1 == op2) : (op1 != op2));
    assign target = instPc + immB;

    // hold off the wrong-path instruction while the redirect is out.
    assign instReady = (!exValid || exReady) && !takenR;
    assign accept = instValid && instReady;

    //////////////////////////////
    // execute register.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exValid <= 1'b0;
            takenR <= 1'b0;
        end else begin
            takenR <= accept && taken; // one cycle only.
            if (accept) exValid <= 1'b1;
            else if (exReady) exValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            exPc <= instPc;
            exRd <= writes ? instWord.rType.rd : 5'd0;
            exWrite <= writes;
            exData <= writes ? aluResult : '0;
            targetR <= target;
        end
    end

    assign redirectValid = takenR;
    assign redirectPc = targetR;

endmodule

`default_nettype wire

// File: logic/commitStage.sv
`timescale 1ns/1ns
`default_nettype none

module commitStage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        exValid,
    input  logic [corePkg::XLen-1:0]    exPc,
    input  logic [4:0]                  exRd,
    input  logic                        exWrite,
    input  logic [corePkg::XLen-1:0]    exData,
    output logic                        exReady,
    output logic                        fwdValid,
    output logic [4:0]                  fwdRd,
    output logic [corePkg::XLen-1:0]    fwdData,
    output logic                        rfWriteEn,
    output logic [4:0]                  rfWriteAddr,
    output logic [corePkg::XLen-1:0]    rfWriteData,
    output logic                        commitValid,
    output logic [corePkg::XLen-1:0]    commitPc,
    output logic [4:0]                  commitRd,
    output logic [corePkg::XLen-1:0]    commitData,
    input  logic                        commitReady
);

    logic accept;

    assign exReady = !commitValid || commitReady;
    assign accept = exValid && exReady;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commitValid <= 1'b0;
        end else if (accept) begin
            commitValid <= 1'b1;
        end else if (commitReady) begin
            commitValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            commitPc <= exPc;
            commitRd <= exRd;     // already zero for branches and x0.
            commitData <= exData;
        end
    end

    // the register file takes the result on the entry edge.
    assign rfWriteEn = accept && exWrite && exRd != 5'd0;
    assign rfWriteAddr = exRd;
    assign rfWriteData = exData;

    // bypass for the result written on that same edge.
    assign fwdValid = exValid && exWrite;
    assign fwdRd = exRd;
    assign fwdData = exData;

endmodule

`default_nettype wire

// File: logic/coreTop.sv
`timescale 1ns/1ns
`default_nettype none

module coreTop (
    input  logic                        clk,
    input  logic                        rst,
    output logic                        imemReqValid,
    output logic [corePkg::XLen-1:0]    imemAddr,
    input  logic                        imemReqReady,
    input  logic                        imemRespValid,
    input  logic [31:0]                 imemRespData,
    output logic                        commitValid,
    output logic [corePkg::XLen-1:0]    commitPc,
    output logic [4:0]                  commitRd,
    output logic [corePkg::XLen-1:0]    commitData,
    input  logic                        commitReady
);

    logic instValid, instReady, redirectValid;
    logic exValid, exReady, exWrite, fwdValid, rfWriteEn;
    logic [corePkg::XLen-1:0] instPc, redirectPc, exPc, exData, fwdData, rfWriteData;
    logic [corePkg::XLen-1:0] rs1Data, rs2Data;
    logic [4:0] rs1Addr, rs2Addr, exRd, fwdRd, rfWriteAddr;
    corePkg::instrWord instWord;

    fetchUnit uFetch (
        .clk, .rst, .imemReqValid, .imemAddr, .imemReqReady, .imemRespValid,
        .imemRespData, .redirectValid, .redirectPc, .instValid, .instPc,
        .instWord, .instReady
    );

    executeStage uExecute (
        .clk, .rst, .instValid, .instPc, .instWord, .instReady, .rs1Addr,
        .rs2Addr, .rs1Data, .rs2Data, .fwdValid, .fwdRd, .fwdData,
        .redirectValid, .redirectPc, .exValid, .exPc, .exRd, .exWrite,
        .exData, .exReady
    );

    commitStage uCommit (
        .clk, .rst, .exValid, .exPc, .exRd, .exWrite, .exData, .exReady,
        .fwdValid, .fwdRd, .fwdData, .rfWriteEn, .rfWriteAddr, .rfWriteData,
        .commitValid, .commitPc, .commitRd, .commitData, .commitReady
    );

    regFile uRegFile (
        .clk,
        .rst,
        .rs1Addr,
        .rs2Addr,
        .rs1Data,
        .rs2Data,
        .writeEn(rfWriteEn),
        .writeAddr(rfWriteAddr),
        .writeData(rfWriteData)
    );

endmodule

`default_nettype wire

// File: sim/coreTop_sva.sv
`timescale 1ns/1ns
`default_nettype none

module coreTopSva (
    input wire logic                        clk,
    input wire logic                        rst,
    input wire logic                        imemReqValid,
    input wire logic [corePkg::XLen-1:0]    imemAddr,
    input wire logic                        imemReqReady,
    input wire logic                        imemRespValid,
    input wire logic                        commitValid,
    input wire logic [corePkg::XLen-1:0]    commitPc,
    input wire logic [4:0]                  commitRd,
    input wire logic [corePkg::XLen-1:0]    commitData,
    input wire logic                        commitReady
);

    logic outstanding; // request sent, response not yet back.
    int failCount = 0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) outstanding <= 1'b0;
        else if (imemReqValid && imemReqReady) outstanding <= 1'b1;
        else if (imemRespValid) outstanding <= 1'b0;
    end

    reqHold: assert property (@(posedge clk) disable iff (rst)
        imemReqValid && !imemReqReady |=> imemReqValid && $stable(imemAddr))
        else begin
            $error("instruction request dropped or changed before acceptance");
            failCount++;
        end

    commitHold: assert property (@(posedge clk) disable iff (rst)
        commitValid && !commitReady |=> commitValid && $stable(commitPc) &&
        $stable(commitRd) && $stable(commitData))
        else begin
            $error("commit port changed while stalled");
            failCount++;
        end

    oneOutstanding: assert property (@(posedge clk) disable iff (rst)
        imemReqValid |-> !outstanding)
        else begin
            $error("second instruction request while one is outstanding");
            failCount++;
        end

endmodule

bind coreTop coreTopSva uSva (
    .clk, .rst, .imemReqValid, .imemAddr, .imemReqReady, .imemRespValid,
    .commitValid, .commitPc, .commitRd, .commitData, .commitReady
);

`default_nettype wire

// File: sim/coreModel.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

//////////////////////////////
// architectural state.
logic [corePkg::XLen-1:0] modelRegs [32];
logic [corePkg::XLen-1:0] modelPc;

function automatic corePkg::instrWord modelFetch(input logic [corePkg::XLen-1:0] addr);
    if (addr < ProgWords * 4) return prog[addr[9:2]];
    return 32'h00000013; // addi x0, x0, 0 past the program.
endfunction

function automatic logic [corePkg::XLen-1:0] modelAlu(input corePkg::aluOp op,
        input logic [corePkg::XLen-1:0] a, input logic [corePkg::XLen-1:0] b);
    case (op)
        corePkg::AluSub: return a - b;
        corePkg::AluAnd: return a & b;
        corePkg::AluOr:  return a | b;
        corePkg::AluXor: return a ^ b;
        default:         return a + b;
    endcase
endfunction

task automatic modelReset();
    for (int i = 0; i < 32; i++) begin
        modelRegs[i] = '0;
    end
    modelPc = corePkg::ResetPc;
endtask

// retires one instruction and returns what the commit port should show.
task automatic modelStep(output logic [corePkg::XLen-1:0] pc, output logic [4:0] rd,
        output logic [corePkg::XLen-1:0] data);
    corePkg::instrWord w;
    logic [31:0] raw;
    logic [corePkg::XLen-1:0] a, b, immI, immB, next;
    corePkg::aluOp op;
    logic isAlu;
    w = modelFetch(modelPc);
    raw = w;
    a = modelRegs[w.rType.rs1];
    b = modelRegs[w.rType.rs2];
    immI = {{52{raw[31]}}, raw[31:20]};
    immB = {{51{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
    next = modelPc + 4;
    data = '0;
    isAlu = 1'b1;
    op = corePkg::AluAdd;
    case (w.rType.funct3)
        corePkg::F3AddSub: begin
            if (w.rType.opcode == corePkg::OpReg && w.rType.funct7 == corePkg::F7Sub) begin
                op = corePkg::AluSub;
            end
        end
        corePkg::F3Xor: op = corePkg::AluXor;
        corePkg::F3Or:  op = corePkg::AluOr;
        corePkg::F3And: op = corePkg::AluAnd;
        default: isAlu = 1'b0;
    endcase
    case (w.rType.opcode)
        corePkg::OpReg: data = modelAlu(op, a, b);
        corePkg::OpImm: data = modelAlu(op, a, immI);
        corePkg::OpBranch: begin
            isAlu = 1'b0;
            if ((w.ibType.funct3 == corePkg::F3Beq && a == b) ||
                (w.ibType.funct3 == corePkg::F3Bne && a != b)) begin
                next = modelPc + immB;
            end
        end
        default: isAlu = 1'b0;
    endcase
    rd = (isAlu && w.rType.rd != 5'd0) ? w.rType.rd : 5'd0;
    if (rd == 5'd0) data = '0;
    else modelRegs[rd] = data;
    pc = modelPc;
    modelPc = next;
endtask

`endif

// File: sim/coreTb.sv
`timescale 1ns/1ns
`default_nettype none

module coreTb;

    localparam int ProgWords = 256;
    localparam int NumTests = 6;
    localparam int CyclesPerCommit = 12;

    logic clk;
    logic rst;
    logic imemReqValid;
    logic [corePkg::XLen-1:0] imemAddr;
    logic imemReqReady;
    logic imemRespValid;
    logic [31:0] imemRespData;
    logic commitValid;
    logic [corePkg::XLen-1:0] commitPc;
    logic [4:0] commitRd;
    logic [corePkg::XLen-1:0] commitData;
    logic commitReady;

    corePkg::instrWord prog [ProgWords];

    `include "coreModel.svh"

    logic [corePkg::XLen-1:0] expPc [$];
    logic [4:0] expRd [$];
    logic [corePkg::XLen-1:0] expData [$];
    logic [corePkg::XLen-1:0] respAddr;
    int respWait;
    int readyPct;
    int cycles;
    int errors;
    int checked;
    logic running;
    logic timedOut;
    string names [NumTests] = '{"r-type", "immediate", "dependent chain", "branch",
                                "x0", "back-pressure"};

    coreTop u_dut (
        .clk, .rst, .imemReqValid, .imemAddr, .imemReqReady, .imemRespValid,
        .imemRespData, .commitValid, .commitPc, .commitRd, .commitData, .commitReady
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // compare tasks.
    task automatic compareAddr(input string name, input logic [corePkg::XLen-1:0] exp,
            input logic [corePkg::XLen-1:0] act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compareReg(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compareData(input string name, input logic [corePkg::XLen-1:0] exp,
            input logic [corePkg::XLen-1:0] act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    //////////////////////////////
    // instruction encoders.
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, corePkg::OpReg};
    endfunction

    function automatic logic [31:0] encI(input logic [2:0] f3, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, corePkg::OpImm};
    endfunction

    function automatic logic [31:0] encB(input logic [4:0] rs1, input logic [4:0] rs2);
        logic [12:0] off;
        logic [2:0] f3;
        off = 13'(4 * $urandom_range(8, 1)); // forward only.
        f3 = ($urandom_range(1, 0) == 1) ? corePkg::F3Bne : corePkg::F3Beq;
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], corePkg::OpBranch};
    endfunction

    function automatic logic [4:0] pick(input int lo, input int hi);
        return 5'($urandom_range(hi, lo));
    endfunction

    function automatic logic [31:0] randomAlu(input logic [4:0] rd, input logic [4:0] rs1,
            input logic [4:0] rs2, input logic useImm, input logic [11:0] imm);
        logic [2:0] f3;
        logic [6:0] f7;
        case ($urandom_range(3, 0))
            0:       f3 = corePkg::F3AddSub;
            1:       f3 = corePkg::F3Xor;
            2:       f3 = corePkg::F3Or;
            default: f3 = corePkg::F3And;
        endcase
        f7 = corePkg::F7Base;
        if (f3 == corePkg::F3AddSub && $urandom_range(1, 0) == 1) f7 = corePkg::F7Sub;
        if (useImm) return encI(f3, rd, rs1, imm);
        return encR(f7, f3, rd, rs1, rs2);
    endfunction

    function automatic logic [4:0] maybeZero();
        return ($urandom_range(1, 0) == 1) ? 5'd0 : pick(1, 7);
    endfunction

    task automatic buildProgram(input int t);
        logic [4:0] prevRd;
        logic [4:0] rd;
        logic useImm;
        prevRd = 5'd31; // last register of the preload.
        for (int i = 0; i < ProgWords; i++) begin
            rd = pick(1, 31);
            useImm = ($urandom_range(1, 0) == 1);
            if (i < 31 && t != 4) begin
                prog[i] = encI(corePkg::F3AddSub, 5'(i + 1), 5'd0, 12'($urandom));
            end else begin
                case (t)
                    1: prog[i] = randomAlu(rd, pick(1, 31), pick(1, 31), 1'b0, '0);
                    2: prog[i] = randomAlu(rd, pick(1, 31), 5'd0, 1'b1, 12'($urandom));
                    3: begin
                        prog[i] = randomAlu(rd, prevRd, pick(1, 31), useImm, 12'($urandom));
                        prevRd = rd;
                    end
                    4: begin
                        // small values in x1..x4 so both branch outcomes show up.
                        if (i % 3 == 2) prog[i] = encB(pick(1, 4), pick(1, 4));
                        else prog[i] = randomAlu(pick(1, 4), pick(1, 4), pick(1, 4), 1'b1,
                                                 12'($urandom_range(1, 0)));
                    end
                    5: prog[i] = randomAlu(maybeZero(), maybeZero(), maybeZero(), useImm,
                                           12'($urandom));
                    default: begin
                        if ($urandom_range(4, 0) == 0) prog[i] = encB(pick(1, 7), pick(1, 7));
                        else prog[i] = randomAlu(pick(1, 7), pick(1, 7), pick(1, 7), useImm,
                                                 12'($urandom));
                    end
                endcase
            end
        end
    endtask

    // runs the model over the whole program ahead of the DUT.
    task automatic expectAll();
        logic [corePkg::XLen-1:0] pc;
        logic [corePkg::XLen-1:0] data;
        logic [4:0] rd;
        expPc.delete();
        expRd.delete();
        expData.delete();
        modelReset();
        while (modelPc < ProgWords * 4) begin
            modelStep(pc, rd, data);
            expPc.push_back(pc);
            expRd.push_back(rd);
            expData.push_back(data);
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
    endtask

    //////////////////////////////
    // memory, ready toggles and commit checking.
    always @(posedge clk) begin
        imemRespValid <= 1'b0;
        if (rst) begin
            respWait = 0;
        end else begin
            if (imemReqValid && imemReqReady) begin
                respAddr = imemAddr;
                respWait = $urandom_range(4, 1);
            end
            if (respWait > 0) begin
                respWait = respWait - 1;
                if (respWait == 0) begin
                    imemRespValid <= 1'b1;
                    imemRespData <= modelFetch(respAddr);
                end
            end
        end
        imemReqReady <= ($urandom_range(99, 0) < readyPct);
        commitReady <= ($urandom_range(99, 0) < readyPct);
        if (running) begin
            cycles = cycles + 1;
            if (commitValid && commitReady && expPc.size() > 0) begin
                compareAddr("commitPc", expPc[0], commitPc);
                compareReg("commitRd", expRd[0], commitRd);
                compareData("commitData", expData[0], commitData);
                void'(expPc.pop_front());
                void'(expRd.pop_front());
                void'(expData.pop_front());
                checked++;
            end
        end
    end

    initial begin
        int limit;
        int startErrors;
        int commits;
        void'($urandom(32'h64f5b43d));
        rst = 1'b1;
        imemReqReady = 1'b0;
        imemRespValid = 1'b0;
        imemRespData = '0;
        commitReady = 1'b0;
        respWait = 0;
        readyPct = 85;
        cycles = 0;
        errors = 0;
        checked = 0;
        running = 1'b0;
        timedOut = 1'b0;
        for (int t = 1; t <= NumTests && !timedOut; t++) begin
            buildProgram(t);
            expectAll();
            readyPct = (t == NumTests) ? 50 : 85; // last test stalls hardest.
            applyReset();
            commits = expPc.size();
            limit = commits * CyclesPerCommit + 32;
            startErrors = errors;
            cycles = 0;
            running = 1'b1;
            while (expPc.size() > 0 && cycles < limit) @(negedge clk);
            running = 1'b0;
            if (expPc.size() > 0) begin
                timedOut = 1'b1;
                $display("test %0d (%s) timed out after %0d cycles, %0d commits never came",
                         t, names[t - 1], cycles, expPc.size());
            end else begin
                $display("test %0d (%s): %0d commits, %0d errors", t, names[t - 1],
                         commits, errors - startErrors);
            end
        end
        $display("commits checked %0d, errors %0d, assertion failures %0d, timeouts %0d",
                 checked, errors, u_dut.uSva.failCount, timedOut ? 1 : 0);
        if (timedOut || errors != 0 || u_dut.uSva.failCount != 0) begin
            $display("Some tests failed");
        end else begin
            $display("All tests passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+sim
logic/corePkg.sv
logic/regFile.sv
logic/fetchUnit.sv
logic/executeStage.sv
logic/commitStage.sv
logic/coreTop.sv
sim/coreTop_sva.sv
sim/coreTb.sv

// File: run.sh
#!/bin/sh
# builds the core testbench with Verilator and runs it into sim.log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module coreTb -o coreSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/coreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the verdict.
if grep -q "All tests passed" sim.log; then
    exit 0
else
    echo "pass line not found in sim.log"
    exit 1
fi
